// ==== Bender.yml ====
package:
  name: ecc_114_cal

sources:
  - files:
      - hdl/ecc_pkg.sv
      - hdl/ecc_parity_gen.sv
      - hdl/ecc_syndrome_decode.sv
      - hdl/ecc_handshake_ctrl.sv
      - hdl/ecc_114_cal.sv

  - target: test
    files:
      - test/ecc_checker.sv
      - test/ecc_114_cal_tb.sv

// ==== build.f ====
hdl/ecc_pkg.sv
hdl/ecc_parity_gen.sv
hdl/ecc_syndrome_decode.sv
hdl/ecc_handshake_ctrl.sv
hdl/ecc_114_cal.sv
test/ecc_checker.sv
test/ecc_114_cal_tb.sv

// ==== test/ecc_114_cal_tb.sv ====
`timescale 1ns/1ps

module ecc_114_cal_tb;

    localparam int num_words  = 400;
    localparam int clk_period = 20;
    localparam int dw         = ecc_pkg::data_width;
    localparam int pw         = ecc_pkg::parity_width;

    logic              clk;
    logic              rst;
    logic              req;
    ecc_pkg::ecc_req_t req_data;
    logic              ack;
    ecc_pkg::ecc_rsp_t rsp_data;
    int                value_errors;
    int                protocol_errors;
    int                words_checked;
    int                seed;
    logic [pw-1:0]     columns [dw];

    ecc_114_cal ecc_114_cal_i (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .req_data (req_data),
        .ack      (ack),
        .rsp_data (rsp_data)
    );

    ecc_checker ecc_checker_i (
        .clk             (clk),
        .rst             (rst),
        .req             (req),
        .req_data        (req_data),
        .ack             (ack),
        .rsp_data        (rsp_data),
        .value_errors    (value_errors),
        .protocol_errors (protocol_errors),
        .words_checked   (words_checked)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(clk_period / 2) clk = ~clk;
        end
    end

    // hamming positions skip every power of two, top bit keeps odd weight.
    initial begin
        int pos;
        int next_pow;

        pos      = 1;
        next_pow = 1;
        for (int i = 0; i < dw; i++) begin
            while (pos == next_pow) begin
                pos++;
                next_pow = next_pow * 2;
            end
            columns[i] = {~^pos[pw-2:0], pos[pw-2:0]};
            pos++;
        end
    end

    function automatic logic [pw-1:0] check_bits(input logic [dw-1:0] data);
        logic [pw-1:0] bits;

        bits = '0;
        for (int i = 0; i < dw; i++) begin
            if (data[i]) begin
                bits ^= columns[i];
            end
        end
        return bits;
    endfunction

    function automatic int pick_below(input int limit);
        return $unsigned($random(seed)) % limit;
    endfunction

    // random word with clean, single data, single check or double error.
    task automatic make_word(output ecc_pkg::ecc_req_t word);
        logic [127:0]     raw;
        logic [dw+pw-1:0] code;
        int               a;
        int               b;

        raw  = {$random(seed), $random(seed), $random(seed), $random(seed)};
        code = {raw[dw-1:0], check_bits(raw[dw-1:0])};
        case (pick_below(4))
            1: begin
                a       = pw + pick_below(dw);
                code[a] = ~code[a];
            end
            2: begin
                a       = pick_below(pw);
                code[a] = ~code[a];
            end
            3: begin
                a = pick_below(dw + pw);
                b = a;
                while (b == a) begin
                    b = pick_below(dw + pw);
                end
                code[a] = ~code[a];
                code[b] = ~code[b];
            end
            default: begin
            end
        endcase
        word.data   = code[dw+pw-1:pw];
        word.parity = code[pw-1:0];
        word.bypass = (pick_below(6) == 0);
    endtask

    // called 2 ns after a rising edge with ack low.
    task automatic run_exchange(input ecc_pkg::ecc_req_t word, input int hold);
        req_data = word;
        req      = 1'b1;
        @(posedge clk);
        #2;
        while (ack !== 1'b1) begin
            @(posedge clk);
            #2;
        end
        repeat (hold) begin
            @(posedge clk);
            #2;
        end
        req = 1'b0;
        while (ack !== 1'b0) begin
            @(posedge clk);
            #2;
        end
    endtask

    initial begin
        #(num_words * 6 * clk_period + 100 * clk_period);
        $display("timeout: the exchanges did not finish in the expected time");
        $display("Something failed");
        $finish;
    end

    initial begin
        ecc_pkg::ecc_req_t word;
        int                missing;

        seed     = 32'hd1d5;
        rst      = 1'b1;
        req      = 1'b0;
        req_data = '0;
        repeat (3) begin
            @(posedge clk);
        end
        #2;
        rst = 1'b0;
        for (int n = 0; n < num_words; n++) begin
            make_word(word);
            run_exchange(word, pick_below(4));
        end
        repeat (2) begin
            @(posedge clk);
        end
        missing = num_words - words_checked;
        $display("errors: %0d value, %0d protocol, %0d words missing",
                 value_errors, protocol_errors, missing);
        if (value_errors == 0 && protocol_errors == 0 && missing == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== test/ecc_checker.sv ====
`timescale 1ns/1ps

module ecc_checker (
    input  logic              clk,
    input  logic              rst,
    input  logic              req,
    input  ecc_pkg::ecc_req_t req_data,
    input  logic              ack,
    input  ecc_pkg::ecc_rsp_t rsp_data,
    output int                value_errors,
    output int                protocol_errors,
    output int                words_checked
);

    localparam int dw = ecc_pkg::data_width;
    localparam int pw = ecc_pkg::parity_width;

    // expected position in the four-phase exchange.
    localparam int ph_idle = 0;
    localparam int ph_calc = 1;
    localparam int ph_ack  = 2;

    logic [pw-1:0]     columns [dw];
    ecc_pkg::ecc_rsp_t expected;
    ecc_pkg::ecc_rsp_t held;
    int                phase;
    logic              first_ack;
    logic              in_reset;

    // odd-weight columns over the positions that are not powers of two.
    initial begin
        int pos;

        pos = 3;
        for (int i = 0; i < dw; i++) begin
            while ($countones(pos) < 2) begin
                pos++;
            end
            columns[i] = {~^pos[pw-2:0], pos[pw-2:0]};
            pos++;
        end
        value_errors    = 0;
        protocol_errors = 0;
        words_checked   = 0;
        phase           = ph_idle;
        first_ack       = 1'b0;
        in_reset        = 1'b1;
    end

    function automatic ecc_pkg::ecc_rsp_t model_response(input ecc_pkg::ecc_req_t r);
        ecc_pkg::ecc_rsp_t rsp;
        logic [pw-1:0]     syn;

        rsp.parity = '0;
        for (int i = 0; i < dw; i++) begin
            if (r.data[i]) begin
                rsp.parity ^= columns[i];
            end
        end
        rsp.data     = r.data;
        rsp.sbit_err = 1'b0;
        rsp.dbit_err = 1'b0;
        syn          = rsp.parity ^ r.parity;
        if (r.bypass || syn == '0) begin
            return rsp;
        end
        // a single flipped check bit leaves the data alone.
        if ($countones(syn) == 1) begin
            rsp.sbit_err = 1'b1;
            return rsp;
        end
        for (int i = 0; i < dw; i++) begin
            if (columns[i] == syn) begin
                rsp.data[i]  = ~rsp.data[i];
                rsp.sbit_err = 1'b1;
                return rsp;
            end
        end
        rsp.dbit_err = 1'b1;
        return rsp;
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            phase    = ph_idle;
            in_reset = 1'b1;
        end else begin
            if (in_reset && rsp_data !== '0) begin
                value_errors++;
                $display("CHECK FAILED at %0t: response register not zero after reset", $time);
            end
            in_reset = 1'b0;
            if (ack !== (phase == ph_ack)) begin
                protocol_errors++;
                $display("protocol fault at %0t: ack was %b but should have been %b",
                         $time, ack, phase == ph_ack);
            end
            case (phase)
                ph_idle: begin
                    if (req) begin
                        expected = model_response(req_data);
                        phase    = ph_calc;
                    end
                end
                ph_calc: begin
                    phase     = ph_ack;
                    first_ack = 1'b1;
                end
                default: begin
                    if (first_ack) begin
                        if (rsp_data !== expected) begin
                            value_errors++;
                            $display("CHECK FAILED at %0t: got %h %h %b%b, expected %h %h %b%b",
                                     $time, rsp_data.data, rsp_data.parity, rsp_data.sbit_err,
                                     rsp_data.dbit_err, expected.data, expected.parity,
                                     expected.sbit_err, expected.dbit_err);
                        end
                        held      = rsp_data;
                        first_ack = 1'b0;
                        words_checked++;
                    end else if (rsp_data !== held) begin
                        value_errors++;
                        $display("CHECK FAILED at %0t: response changed while ack was high", $time);
                    end
                    if (!req) begin
                        phase = ph_idle;
                    end
                end
            endcase
        end
    end

endmodule

// ==== hdl/ecc_114_cal.sv ====
`timescale 1ns/1ps

module ecc_114_cal (
    input  logic              clk,
    input  logic              rst,
    input  logic              req,
    input  ecc_pkg::ecc_req_t req_data,
    output logic              ack,
    output ecc_pkg::ecc_rsp_t rsp_data
);

    ecc_pkg::ecc_req_t                cur_req;
    ecc_pkg::ecc_rsp_t                next_rsp;
    logic [ecc_pkg::parity_width-1:0] gen_parity;
    logic [ecc_pkg::parity_width-1:0] syndrome;
    logic [ecc_pkg::data_width-1:0]   mask;
    ecc_pkg::err_class_e              err_class;

    ecc_handshake_ctrl ecc_handshake_ctrl_i (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .req_data (req_data),
        .ack      (ack),
        .rsp_data (rsp_data),
        .cur_req  (cur_req),
        .next_rsp (next_rsp)
    );

    ecc_parity_gen ecc_parity_gen_i (
        .data   (cur_req.data),
        .parity (gen_parity)
    );

    // differs from zero wherever received and recomputed check bits disagree.
    assign syndrome = gen_parity ^ cur_req.parity;

    ecc_syndrome_decode ecc_syndrome_decode_i (
        .syndrome  (syndrome),
        .mask      (mask),
        .err_class (err_class)
    );

    // bypass passes the raw word and hides the decode result.
    always_comb begin
        next_rsp.parity = gen_parity;
        if (cur_req.bypass) begin
            next_rsp.data     = cur_req.data;
            next_rsp.sbit_err = 1'b0;
            next_rsp.dbit_err = 1'b0;
        end else begin
            next_rsp.data     = cur_req.data ^ mask;
            next_rsp.sbit_err = (err_class == ecc_pkg::err_single);
            next_rsp.dbit_err = (err_class == ecc_pkg::err_double);
        end
    end

endmodule

// ==== hdl/ecc_handshake_ctrl.sv ====
`timescale 1ns/1ps

module ecc_handshake_ctrl (
    input  logic              clk,
    input  logic              rst,
    input  logic              req,
    input  ecc_pkg::ecc_req_t req_data,
    output logic              ack,
    output ecc_pkg::ecc_rsp_t rsp_data,
    output ecc_pkg::ecc_req_t cur_req,
    input  ecc_pkg::ecc_rsp_t next_rsp
);

    typedef enum logic [1:0] {
        hs_idle,
        hs_calc,
        hs_ack
    } hs_state_e;

    hs_state_e         state;
    hs_state_e         next_state;
    ecc_pkg::ecc_req_t req_q;
    ecc_pkg::ecc_rsp_t rsp_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= hs_idle;
        end else begin
            state <= next_state;
        end
    end

    // four-phase sequence: capture, compute, hold ack until req drops.
    always_comb begin
        next_state = state;
        case (state)
            hs_idle: begin
                if (req) begin
                    next_state = hs_calc;
                end
            end
            hs_calc: begin
                next_state = hs_ack;
            end
            hs_ack: begin
                if (!req) begin
                    next_state = hs_idle;
                end
            end
            default: begin
                next_state = hs_idle;
            end
        endcase
    end

    // request word, taken once per exchange.
    always_ff @(posedge clk) begin
        if (state == hs_idle && req) begin
            req_q <= req_data;
        end
    end

    // response word, held stable for as long as ack is high.
    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_q <= '0;
        end else if (state == hs_calc) begin
            rsp_q <= next_rsp;
        end
    end

    assign ack      = (state == hs_ack);
    assign cur_req  = req_q;
    assign rsp_data = rsp_q;

endmodule

// ==== hdl/ecc_syndrome_decode.sv ====
`timescale 1ns/1ps

module ecc_syndrome_decode (
    input  logic [ecc_pkg::parity_width-1:0] syndrome,
    output logic [ecc_pkg::data_width-1:0]   mask,
    output ecc_pkg::err_class_e              err_class
);

    // one-hot match of the syndrome against each data column.
    logic [ecc_pkg::data_width-1:0] hit;

    genvar i;

    generate
        for (i = 0; i < ecc_pkg::data_width; i++) begin : g_col
            localparam logic [ecc_pkg::parity_width-1:0] col = ecc_pkg::ecc_column(i);

            assign hit[i] = (syndrome == col);
        end
    endgenerate

    // columns are distinct and of odd weight three or more, so at most one
    // hit is set and a data hit never looks like a check bit error.
    always_comb begin
        mask      = '0;
        err_class = ecc_pkg::err_none;
        if (syndrome == '0) begin
            err_class = ecc_pkg::err_none;
        end else if (|hit) begin
            mask      = hit;
            err_class = ecc_pkg::err_single;
        end else if ($onehot(syndrome)) begin
            // a flipped check bit, data is left alone.
            err_class = ecc_pkg::err_single;
        end else begin
            // even weight or unused column.
            err_class = ecc_pkg::err_double;
        end
    end

endmodule

// ==== hdl/ecc_parity_gen.sv ====
`timescale 1ns/1ps

module ecc_parity_gen (
    input  logic [ecc_pkg::data_width-1:0]   data,
    output logic [ecc_pkg::parity_width-1:0] parity
);

    // data bits whose column has bit k set.
    function automatic logic [ecc_pkg::data_width-1:0] row_select(input int k);
        logic [ecc_pkg::data_width-1:0]   sel;
        logic [ecc_pkg::parity_width-1:0] col;

        sel = '0;
        for (int i = 0; i < ecc_pkg::data_width; i++) begin
            col    = ecc_pkg::ecc_column(i);
            sel[i] = col[k];
        end
        return sel;
    endfunction

    genvar k;

    // one xor tree per check bit, selection fixed at elaboration.
    generate
        for (k = 0; k < ecc_pkg::parity_width; k++) begin : g_check
            localparam logic [ecc_pkg::data_width-1:0] sel = row_select(k);

            assign parity[k] = ^(data & sel);
        end
    endgenerate

endmodule

// ==== hdl/ecc_pkg.sv ====
package ecc_pkg;

    // data bits carried by one word.
    localparam int data_width = 114;

    // check bits per word; the top one keeps every column at odd weight.
    localparam int parity_width = 8;

    // hamming positions live below this bound.
    localparam int position_limit = 2 ** (parity_width - 1);

    // column of data bit index in the parity check matrix.
    // the index-th position from 3 upwards that is not a power of two
    // gives the low bits, and the top bit is set on even weight.
    function automatic logic [parity_width-1:0] ecc_column(input int index);
        logic [parity_width-1:0] col;
        int                      count;

        col   = '0;
        count = 0;
        for (int pos = 3; pos < position_limit; pos++) begin
            if ((pos & (pos - 1)) != 0) begin
                if (count == index) begin
                    col[parity_width-2:0] = pos[parity_width-2:0];
                end
                count++;
            end
        end
        col[parity_width-1] = ~^col[parity_width-2:0];
        return col;
    endfunction

    // outcome of the syndrome decode.
    typedef enum logic [1:0] {
        err_none,
        err_single,
        err_double
    } err_class_e;

    // one request word as received.
    typedef struct packed {
        logic [data_width-1:0]   data;
        logic [parity_width-1:0] parity;
        logic                    bypass;
    } ecc_req_t;

    // one response word.
    // parity is generated from the received data, before correction.
    typedef struct packed {
        logic [data_width-1:0]   data;
        logic [parity_width-1:0] parity;
        logic                    sbit_err;
        logic                    dbit_err;
    } ecc_rsp_t;

endpackage
